// ==== verilog.f ====
common/fetch_pkg.sv
fetch1/addr_trans.sv
fetch1/fetch1.sv
rtl/btb.sv
rtl/fetch2.sv
rtl/fetch_front.sv
sim/tb_fetch_front.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_front
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_fetch_front.sv ====
`timescale 1ns/100ps

module tb_fetch_front;

    localparam fetch_pkg::u32_t NOP_WORD = 32'h0340_0000;     // andi r0, r0, 0
    localparam int LONG_RUN    = 1000;
    localparam int TEST_INSTS  = 62 + LONG_RUN;
    // about two cycles per instruction under random stalls and twice that as margin
    localparam int CYCLE_LIMIT = 2 * 2 * TEST_INSTS;

    logic                   clk = 1'b0;
    logic                   rst_n;
    fetch_pkg::csr_t        csr;
    fetch_pkg::wr_pc_req_t  ex_wr_pc_req;
    fetch_pkg::wr_pc_req_t  excp_wr_pc_req;
    fetch_pkg::btb_update_t btb_update;
    logic                   flush;
    logic                   decode_rdy;
    logic [11:0]            icache_idx;
    fetch_pkg::icache_op_t  icache_op;
    fetch_pkg::u32_t        icache_pa;
    logic                   icache_is_cached;
    logic                   icache_busy;
    fetch_pkg::u32_t        icache_rdata;
    fetch_pkg::inst_pass_t  inst_out;

    fetch_pkg::csr_t        csr_direct;
    fetch_pkg::csr_t        csr_mapped;
    logic [31:0]            imem [logic [31:0]];       // sparse and indexed by physical address
    int                     br_words [logic [31:0]];   // word offset of each placed branch
    fetch_pkg::u32_t        exp_pc;
    int                     n_consumed;
    int                     cycles = 0;
    logic                   stalls_on = 1'b0;
    fetch_pkg::u32_t        trained_pc = 32'h0;
    fetch_pkg::inst_pass_t  prev_out;
    logic                   prev_hold = 1'b0;
    fetch_pkg::u32_t        fetched_word;
    logic                   check_inst;

    fetch_front i_fetch_front (
        .clk              (clk),
        .rst_n            (rst_n),
        .csr              (csr),
        .ex_wr_pc_req     (ex_wr_pc_req),
        .excp_wr_pc_req   (excp_wr_pc_req),
        .btb_update       (btb_update),
        .flush            (flush),
        .decode_rdy       (decode_rdy),
        .icache_idx       (icache_idx),
        .icache_op        (icache_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .icache_busy      (icache_busy),
        .icache_rdata     (icache_rdata),
        .inst_out         (inst_out)
    );

    always #50 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    function automatic logic win_hit(input fetch_pkg::dmw_t dmw, input fetch_pkg::u32_t va);
        logic plv_ok;
        plv_ok = (csr.crmd.plv == 2'd0 && dmw.plv0) || (csr.crmd.plv == 2'd3 && dmw.plv3);
        return plv_ok && dmw.vseg == va[31:29];
    endfunction

    function automatic fetch_pkg::u32_t phys_addr(input fetch_pkg::u32_t va);
        if (csr.crmd.da || !(win_hit(csr.dmw0, va) || win_hit(csr.dmw1, va))) begin
            return va;
        end
        if (win_hit(csr.dmw0, va)) begin
            return {csr.dmw0.pseg, va[28:0]};
        end
        return {csr.dmw1.pseg, va[28:0]};
    endfunction

    function automatic logic phys_cached(input fetch_pkg::u32_t va);
        if (csr.crmd.da) begin
            return csr.crmd.datf[0];
        end
        if (win_hit(csr.dmw0, va)) begin
            return csr.dmw0.mat[0];
        end
        return csr.dmw1.mat[0];
    endfunction

    function automatic fetch_pkg::ecode_t fetch_fault(input fetch_pkg::u32_t va);
        if (va[1:0] != 2'b00) begin
            return fetch_pkg::ECODE_ADEF;
        end
        if (!csr.crmd.da && !win_hit(csr.dmw0, va) && !win_hit(csr.dmw1, va)) begin
            return fetch_pkg::ECODE_TLBR;
        end
        return fetch_pkg::ECODE_NONE;
    endfunction

    function automatic fetch_pkg::u32_t mem_word(input fetch_pkg::u32_t pa);
        if (imem.exists(pa)) begin
            return imem[pa];
        end
        return NOP_WORD;
    endfunction

    // B with a signed word offset split as offs[15:0] in bits 25:10 and offs[25:16] in bits 9:0
    function automatic fetch_pkg::u32_t b_word(input int words);
        logic [25:0] offs;
        offs = 26'(words);
        return {6'b010100, offs[15:0], offs[25:16]};
    endfunction

    task automatic place_branch(input fetch_pkg::u32_t pa, input int words);
        imem[pa]     = b_word(words);
        br_words[pa] = words;
    endtask

    // a placed branch jumps four bytes per word of offset
    function automatic fetch_pkg::u32_t next_pc(input fetch_pkg::u32_t pc);
        fetch_pkg::u32_t pa;
        pa = phys_addr(pc);
        if (fetch_fault(pc) == fetch_pkg::ECODE_NONE && br_words.exists(pa)) begin
            return pc + 32'(br_words[pa] * 4);
        end
        return pc + 32'd4;
    endfunction

    // cache model with one cycle of read latency
    always @(posedge clk) begin
        if (icache_op == fetch_pkg::IC_R && !icache_busy) begin
            fetched_word = mem_word(icache_pa);
            #1;
            icache_rdata = fetched_word;
        end
    end

    // reference pc model that follows what decode consumes
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc     <= fetch_pkg::RESET_PC;
            n_consumed <= 0;
        end else if (flush && (excp_wr_pc_req.valid || ex_wr_pc_req.valid)) begin
            exp_pc <= excp_wr_pc_req.valid ? excp_wr_pc_req.pc : ex_wr_pc_req.pc;
        end else if (inst_out.valid && decode_rdy && !flush) begin
            exp_pc     <= next_pc(exp_pc);
            n_consumed <= n_consumed + 1;
        end
    end

    always @(posedge clk) begin
        prev_out  <= inst_out;
        prev_hold <= rst_n && inst_out.valid && !decode_rdy && !flush;
        cycles    <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            report_failure($sformatf("timeout after %0d cycles", cycles));
        end
    end

    always @(posedge clk) begin
        #1;
        if (stalls_on) begin
            decode_rdy  = ($urandom % 4) != 0;
            icache_busy = ($urandom % 5) == 0;
        end
    end

    assign check_inst = inst_out.valid && !flush;

    assert property (@(negedge clk) disable iff (!rst_n)
        check_inst |-> inst_out.pc == exp_pc)
        else report_mismatch("inst_out.pc", inst_out.pc, exp_pc);

    assert property (@(negedge clk) disable iff (!rst_n)
        check_inst && !inst_out.excp.valid |->
            inst_out.inst == mem_word(phys_addr(inst_out.pc)))
        else report_mismatch("inst_out.inst", inst_out.inst,
                             mem_word(phys_addr(inst_out.pc)));

    assert property (@(negedge clk) disable iff (!rst_n)
        check_inst |-> inst_out.excp.ecode == fetch_fault(inst_out.pc) &&
            inst_out.excp.valid == (fetch_fault(inst_out.pc) != fetch_pkg::ECODE_NONE))
        else report_mismatch("inst_out.excp.ecode", 32'(inst_out.excp.ecode),
                             32'(fetch_fault(inst_out.pc)));

    assert property (@(negedge clk) disable iff (!rst_n)
        check_inst && inst_out.excp.valid |-> inst_out.excp.badv == inst_out.pc)
        else report_mismatch("inst_out.excp.badv", inst_out.excp.badv, inst_out.pc);

    assert property (@(negedge clk) disable iff (!rst_n)
        prev_hold |-> inst_out == prev_out)
        else report_mismatch("inst_out.inst", inst_out.inst, prev_out.inst);

    assert property (@(negedge clk) disable iff (!rst_n)
        check_inst && inst_out.pc == trained_pc |-> !i_fetch_front.if2_wr_pc_req.valid)
        else report_failure("predecode redirect on a branch the btb already predicts");

    // cache requests against the pc held in fetch1
    assert property (@(negedge clk) disable iff (!rst_n)
        icache_op == fetch_pkg::IC_R |-> icache_pa == phys_addr(i_fetch_front.i_fetch1.pc_r))
        else report_mismatch("icache_pa", icache_pa, phys_addr(i_fetch_front.i_fetch1.pc_r));

    assert property (@(negedge clk) disable iff (!rst_n)
        icache_op == fetch_pkg::IC_R |-> icache_idx == i_fetch_front.i_fetch1.pc_r[11:0])
        else report_mismatch("icache_idx", 32'(icache_idx),
                             32'(i_fetch_front.i_fetch1.pc_r[11:0]));

    assert property (@(negedge clk) disable iff (!rst_n)
        icache_op == fetch_pkg::IC_R |->
            icache_is_cached == phys_cached(i_fetch_front.i_fetch1.pc_r))
        else report_mismatch("icache_is_cached", 32'(icache_is_cached),
                             32'(phys_cached(i_fetch_front.i_fetch1.pc_r)));

    assert property (@(negedge clk) disable iff (!rst_n)
        icache_op == fetch_pkg::IC_R |->
            fetch_fault(i_fetch_front.i_fetch1.pc_r) == fetch_pkg::ECODE_NONE)
        else report_failure("cache read issued for a pc that should fault");

    task automatic wait_insts(input int n);
        int target;
        target = n_consumed + n;
        while (n_consumed < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one-cycle backend flush with redirects and a csr switch in the same cycle
    task automatic backend_redirect(input logic use_excp, input fetch_pkg::u32_t excp_pc,
                                    input logic use_ex, input fetch_pkg::u32_t ex_pc,
                                    input fetch_pkg::csr_t new_csr);
        flush                = 1'b1;
        excp_wr_pc_req.valid = use_excp;
        excp_wr_pc_req.pc    = excp_pc;
        ex_wr_pc_req.valid   = use_ex;
        ex_wr_pc_req.pc      = ex_pc;
        csr                  = new_csr;
        @(posedge clk);
        #1;
        flush          = 1'b0;
        excp_wr_pc_req = '0;
        ex_wr_pc_req   = '0;
    endtask

    task automatic train_btb(input fetch_pkg::u32_t pc, input fetch_pkg::u32_t target);
        btb_update.valid  = 1'b1;
        btb_update.pc     = pc;
        btb_update.target = target;
        trained_pc        = pc;
        @(posedge clk);
        #1;
        btb_update = '0;
    endtask

    initial begin
        void'($urandom(32'ha9e5_364c));
        csr_direct             = '0;
        csr_direct.crmd.da     = 1'b1;
        csr_direct.crmd.datf   = 2'b01;
        csr_direct.dmw0.plv0   = 1'b1;
        csr_direct.dmw0.mat    = 2'b00;
        csr_direct.dmw0.pseg   = 3'b000;
        csr_direct.dmw0.vseg   = 3'b101;                // 0xa0000000 window onto 0x0
        csr_mapped             = csr_direct;
        csr_mapped.crmd.da     = 1'b0;
        csr_mapped.crmd.pg     = 1'b1;

        rst_n          = 1'b0;
        csr            = csr_direct;
        ex_wr_pc_req   = '0;
        excp_wr_pc_req = '0;
        btb_update     = '0;
        flush          = 1'b0;
        decode_rdy     = 1'b1;
        icache_busy    = 1'b0;
        icache_rdata   = NOP_WORD;

        place_branch(32'h1c00_0010, 8);                 // to 0x1c000030
        place_branch(32'h1c00_0400, 16);                // to 0x1c000440 and trained below
        place_branch(32'h1c00_0510, 4);                 // mapped va 0xbc000510 to 0xbc000520

        repeat (2) @(posedge clk);
        #1;
        rst_n     = 1'b1;
        stalls_on = 1'b1;

        wait_insts(24);
        backend_redirect(1'b1, 32'h1c00_0200, 1'b1, 32'h1c00_0100, csr_direct);
        wait_insts(6);
        backend_redirect(1'b0, 32'h0, 1'b1, 32'h1c00_0300, csr_direct);
        wait_insts(6);
        train_btb(32'h1c00_0400, 32'h1c00_0440);
        backend_redirect(1'b0, 32'h0, 1'b1, 32'h1c00_03f0, csr_direct);
        wait_insts(10);
        backend_redirect(1'b1, 32'hbc00_0500, 1'b0, 32'h0, csr_mapped);
        wait_insts(10);
        backend_redirect(1'b1, 32'hbc00_0602, 1'b0, 32'h0, csr_mapped);  // unaligned
        wait_insts(3);
        backend_redirect(1'b1, 32'h1c00_0700, 1'b0, 32'h0, csr_mapped);  // no window
        wait_insts(3);
        backend_redirect(1'b1, 32'h1c00_0800, 1'b0, 32'h0, csr_direct);
        wait_insts(LONG_RUN);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== rtl/fetch_front.sv ====
`timescale 1ns/100ps

module fetch_front (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fetch_pkg::csr_t        csr,
    input  fetch_pkg::wr_pc_req_t  ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t  excp_wr_pc_req,
    input  fetch_pkg::btb_update_t btb_update,
    input  logic                   flush,
    input  logic                   decode_rdy,
    output logic [11:0]            icache_idx,
    output fetch_pkg::icache_op_t  icache_op,
    output fetch_pkg::u32_t        icache_pa,
    output logic                   icache_is_cached,
    input  logic                   icache_busy,
    input  fetch_pkg::u32_t        icache_rdata,
    output fetch_pkg::inst_pass_t  inst_out
);

    logic                    stall_btb;
    fetch_pkg::u32_t         btb_pc;
    fetch_pkg::btb_predict_t btb_predict;
    fetch_pkg::wr_pc_req_t   if2_wr_pc_req;
    logic                    if1_flush;
    logic                    if1_rdy_in;
    fetch_pkg::fetch1_pass_t if1_pass;

    btb i_btb (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (btb_pc),
        .stall   (stall_btb),
        .predict (btb_predict),
        .update  (btb_update)
    );

    fetch1 i_fetch1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall_btb        (stall_btb),
        .btb_pc           (btb_pc),
        .btb_predict      (btb_predict),
        .if2_wr_pc_req    (if2_wr_pc_req),
        .ex_wr_pc_req     (ex_wr_pc_req),
        .excp_wr_pc_req   (excp_wr_pc_req),
        .csr              (csr),
        .icache_idx       (icache_idx),
        .icache_op        (icache_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .icache_busy      (icache_busy),
        .flush            (if1_flush),
        .next_rdy         (decode_rdy),
        .rdy_in           (if1_rdy_in),
        .pass_out         (if1_pass)
    );

    fetch2 i_fetch2 (
        .clk           (clk),
        .rst_n         (rst_n),
        .pass_in       (if1_pass),
        .accept        (if1_rdy_in),
        .icache_rdata  (icache_rdata),
        .flush         (flush),
        .next_rdy      (decode_rdy),
        .if2_wr_pc_req (if2_wr_pc_req),
        .if1_flush     (if1_flush),
        .inst_out      (inst_out)
    );

endmodule

// ==== rtl/fetch2.sv ====
`timescale 1ns/100ps

module fetch2 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::fetch1_pass_t pass_in,
    input  logic                    accept,
    input  fetch_pkg::u32_t         icache_rdata,
    input  logic                    flush,
    input  logic                    next_rdy,
    output fetch_pkg::wr_pc_req_t   if2_wr_pc_req,
    output logic                    if1_flush,
    output fetch_pkg::inst_pass_t   inst_out
);

    logic                    take;
    logic                    valid_r;
    fetch_pkg::fetch1_pass_t pass_r;
    logic                    fresh_r;
    fetch_pkg::u32_t         hold_r;
    fetch_pkg::u32_t         inst;
    fetch_pkg::opcode_t      opc;
    logic [25:0]             offs;
    fetch_pkg::u32_t         br_target;
    logic                    is_br;
    logic                    mispred;
    logic                    redir_done_r;

    assign take = accept & next_rdy;                // decode must drain the slot first

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r      <= 1'b0;
            fresh_r      <= 1'b0;
            redir_done_r <= 1'b0;
        end else begin
            fresh_r <= take & pass_in.valid & ~flush;
            if (flush) begin
                valid_r <= 1'b0;
            end else if (take) begin
                valid_r <= pass_in.valid;
            end else if (next_rdy) begin
                valid_r <= 1'b0;                    // consumed with nothing behind it
            end
            if (flush || next_rdy) begin
                redir_done_r <= 1'b0;
            end else if (if2_wr_pc_req.valid) begin
                redir_done_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pass_r <= pass_in;
        end
        if (fresh_r) begin
            hold_r <= icache_rdata;                 // cache word only lasts one cycle
        end
    end

    assign inst = fresh_r ? icache_rdata : hold_r;
    assign opc  = fetch_pkg::opcode_t'(inst[31:26]);

    // offs26 is split as offs[15:0] in inst[25:10] and offs[25:16] in inst[9:0]
    assign offs      = {inst[9:0], inst[25:10]};
    assign br_target = pass_r.pc + {{4{offs[25]}}, offs, 2'b00};

    assign is_br   = valid_r & ~pass_r.excp.valid &
                     (opc == fetch_pkg::OPC_B || opc == fetch_pkg::OPC_BL);
    assign mispred = ~pass_r.is_pred | (pass_r.btb_pre != br_target);

    assign if2_wr_pc_req.valid = is_br & mispred & ~redir_done_r & ~flush;
    assign if2_wr_pc_req.pc    = br_target;
    assign if1_flush           = if2_wr_pc_req.valid | flush;

    assign inst_out.valid = valid_r;
    assign inst_out.pc    = pass_r.pc;
    assign inst_out.inst  = inst;
    assign inst_out.excp  = pass_r.excp;

    assert property (@(posedge clk) disable iff (!rst_n)
        if2_wr_pc_req.valid |-> inst_out.valid)
        else $error("fetch2: redirect to %h without a valid instruction", br_target);

endmodule

// ==== rtl/btb.sv ====
`timescale 1ns/100ps

module btb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::u32_t         pc,
    input  logic                    stall,
    output fetch_pkg::btb_predict_t predict,
    input  fetch_pkg::btb_update_t  update
);

    localparam int IDX_W = fetch_pkg::BTB_IDX_W;
    localparam int TAG_W = fetch_pkg::BTB_TAG_W;

    logic [fetch_pkg::BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]                  tag_q    [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::u32_t                   target_q [fetch_pkg::BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [TAG_W-1:0] wr_tag;
    logic             fwd;
    logic             hit;
    fetch_pkg::u32_t  hit_npc;
    logic             pred_valid_r;
    fetch_pkg::u32_t  pred_npc_r;

    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[31:IDX_W+2];
    assign wr_idx = update.pc[IDX_W+1:2];
    assign wr_tag = update.pc[31:IDX_W+2];

    // training the entry being read this cycle overrides the stored contents
    assign fwd = update.valid && (wr_idx == rd_idx);

    always_comb begin
        if (fwd) begin
            hit     = wr_tag == rd_tag;
            hit_npc = update.target;
        end else begin
            hit     = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
            hit_npc = target_q[rd_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (update.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= update.target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid_r <= 1'b0;
        end else if (!stall) begin
            pred_valid_r <= hit;                    // stall keeps the last answer
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pred_npc_r <= hit_npc;
        end
    end

    assign predict.valid = pred_valid_r;
    assign predict.npc   = pred_npc_r;

endmodule

// ==== fetch1/fetch1.sv ====
`timescale 1ns/100ps

module fetch1 (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   stall_btb,
    output fetch_pkg::u32_t        btb_pc,
    input  fetch_pkg::btb_predict_t btb_predict,
    input  fetch_pkg::wr_pc_req_t  if2_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t  ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t  excp_wr_pc_req,
    input  fetch_pkg::csr_t        csr,
    output logic [11:0]            icache_idx,
    output fetch_pkg::icache_op_t  icache_op,
    output fetch_pkg::u32_t        icache_pa,
    output logic                   icache_is_cached,
    input  logic                   icache_busy,
    input  logic                   flush,
    input  logic                   next_rdy,
    output logic                   rdy_in,
    output fetch_pkg::fetch1_pass_t pass_out
);

    fetch_pkg::u32_t       pc_r;
    fetch_pkg::u32_t       npc;
    logic                  is_pred;
    logic                  started_r;
    logic                  stall;
    logic                  rdy_out;
    fetch_pkg::u32_t       pa;
    fetch_pkg::mat_t       mat;
    fetch_pkg::excp_pass_t addr_excp;

    assign stall   = ~next_rdy | icache_busy;
    assign rdy_in  = started_r & (flush | ~stall);      // flush beats a stall
    assign rdy_out = started_r & ~flush & ~stall;       // pc_r really leaves this cycle

    addr_trans i_addr_trans (
        .en   (started_r & ~flush),
        .va   (pc_r),
        .csr  (csr),
        .pa   (pa),
        .mat  (mat),
        .excp (addr_excp)
    );

    assign icache_op        = addr_excp.valid | flush | ~started_r ? fetch_pkg::IC_NOP
                                                                    : fetch_pkg::IC_R;
    assign icache_idx       = pc_r[11:0];
    assign icache_pa        = pa;
    assign icache_is_cached = mat[0];

    // the btb registers npc, so its answer lines up with pc_r next cycle
    assign btb_pc    = npc;
    assign stall_btb = ~rdy_in;

    always_comb begin
        is_pred = 1'b0;
        if (excp_wr_pc_req.valid) begin
            npc = excp_wr_pc_req.pc;
        end else if (ex_wr_pc_req.valid) begin
            npc = ex_wr_pc_req.pc;
        end else if (if2_wr_pc_req.valid) begin
            npc = if2_wr_pc_req.pc;
        end else if (btb_predict.valid) begin
            npc     = btb_predict.npc;                  // predicted from pc_r
            is_pred = 1'b1;
        end else begin
            npc     = pc_r + 32'd4;
            is_pred = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_r      <= fetch_pkg::RESET_PC;
            started_r <= 1'b0;
        end else begin
            started_r <= 1'b1;                          // holds RESET_PC one cycle
            if (rdy_in) begin
                pc_r <= npc;
            end
        end
    end

    always_comb begin
        pass_out            = '0;
        pass_out.valid      = rdy_out;
        pass_out.pc         = pc_r;
        pass_out.is_pred    = is_pred;
        pass_out.btb_pre    = npc;
        pass_out.excp       = addr_excp;
        pass_out.excp.valid = rdy_out & addr_excp.valid;
    end

    // a faulting fetch must never reach the cache
    assert property (@(posedge clk) disable iff (!rst_n)
        pass_out.excp.valid |-> icache_op == fetch_pkg::IC_NOP)
        else $error("fetch1: cache read issued for faulting pc %h", pc_r);

endmodule

// ==== fetch1/addr_trans.sv ====
`timescale 1ns/100ps

module addr_trans (
    input  logic                  en,
    input  fetch_pkg::u32_t       va,
    input  fetch_pkg::csr_t       csr,
    output fetch_pkg::u32_t       pa,
    output fetch_pkg::mat_t       mat,
    output fetch_pkg::excp_pass_t excp
);

    logic direct;
    logic dmw0_hit;
    logic dmw1_hit;
    logic misaligned;
    logic win_miss;

    function automatic logic dmw_match(
        input fetch_pkg::dmw_t dmw,
        input logic [1:0]      plv,
        input logic [2:0]      vtop
    );
        logic plv_ok;
        plv_ok = (plv == 2'd0 && dmw.plv0) || (plv == 2'd3 && dmw.plv3);
        return plv_ok && (dmw.vseg == vtop);
    endfunction

    assign direct   = csr.crmd.da;
    assign dmw0_hit = dmw_match(csr.dmw0, csr.crmd.plv, va[31:29]);
    assign dmw1_hit = dmw_match(csr.dmw1, csr.crmd.plv, va[31:29]);

    assign misaligned = va[1:0] != 2'b00;
    assign win_miss   = ~direct & ~dmw0_hit & ~dmw1_hit;   // no tlb behind the windows

    always_comb begin
        pa  = va;
        mat = csr.crmd.datf;
        if (!direct) begin
            if (dmw0_hit) begin                             // dmw0 wins on overlap
                pa  = {csr.dmw0.pseg, va[28:0]};
                mat = csr.dmw0.mat;
            end else if (dmw1_hit) begin
                pa  = {csr.dmw1.pseg, va[28:0]};
                mat = csr.dmw1.mat;
            end
        end
    end

    always_comb begin
        excp.valid = 1'b0;
        excp.ecode = fetch_pkg::ECODE_NONE;
        excp.badv  = va;
        if (en) begin
            if (misaligned) begin
                excp.valid = 1'b1;
                excp.ecode = fetch_pkg::ECODE_ADEF;
            end else if (win_miss) begin
                excp.valid = 1'b1;
                excp.ecode = fetch_pkg::ECODE_TLBR;
            end
        end
    end

    // direct mode is an identity map
    always_comb begin
        if (csr.crmd.da) begin
            assert (pa == va)
                else $error("addr_trans: direct mode pa %h differs from va %h", pa, va);
        end
    end

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0] u32_t;

    localparam u32_t RESET_PC = 32'h1c00_0000;

    // direct-mapped btb geometry: index from pc[5:2], tag from the bits above
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;

    typedef logic [1:0] mat_t;                 // bit 0 set means cached

    typedef enum logic [5:0] {
        OPC_B  = 6'b010100,
        OPC_BL = 6'b010101
    } opcode_t;

    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_ADEF = 6'h08,
        ECODE_TLBR = 6'h3f
    } ecode_t;

    typedef enum logic [2:0] {
        IC_NOP = 3'd0,
        IC_R   = 3'd1
    } icache_op_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
    } wr_pc_req_t;

    typedef struct packed {
        logic valid;
        u32_t npc;
    } btb_predict_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        u32_t target;
    } btb_update_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        mat_t       mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic       da;
        logic       pg;
        logic [1:0] plv;
        mat_t       datf;                      // mat used in direct mode
    } crmd_t;

    typedef struct packed {
        crmd_t crmd;
        dmw_t  dmw0;
        dmw_t  dmw1;
    } csr_t;

    typedef struct packed {
        logic   valid;
        ecode_t ecode;
        u32_t   badv;
    } excp_pass_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        logic       is_pred;                   // btb_pre came from btb or pc+4
        u32_t       btb_pre;
        excp_pass_t excp;
    } fetch1_pass_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       inst;
        excp_pass_t excp;
    } inst_pass_t;

endpackage
